// File: core_cfg_pkg.sv
/*
 core-wide widths and sizes
 register file, instruction fields and issue queue depth
 */

`default_nettype none

package core_cfg_pkg;

    // datapath and instruction fields
    localparam int XLEN      = 32;
    localparam int PC_W      = 32;
    localparam int REG_AW    = 5;
    localparam int NUM_REGS  = 32;
    localparam int DECINFO_W = 16;

    // issue queue
    localparam int IQ_DEPTH  = 8;
    localparam int IQ_PTR_W  = 3;

endpackage

`default_nettype wire

// File: issue_pkg.sv
/*
 issue stage types
 decoded instruction packet, operand pair and queue index
 */

`default_nettype none

package issue_pkg;

    import core_cfg_pkg::*;

    // one decoded instruction as it sits in the queue
    typedef struct packed {
        logic [PC_W-1:0]      pc;
        logic [REG_AW-1:0]    rd;
        logic [REG_AW-1:0]    rs1;
        logic [REG_AW-1:0]    rs2;
        logic                 we;
        logic [XLEN-1:0]      imm;
        logic [DECINFO_W-1:0] info;
    } inst_pkt_t;

    // source values captured at dispatch
    typedef struct packed {
        logic [XLEN-1:0] op1;
        logic [XLEN-1:0] op2;
    } operands_t;

    // wraps naturally at IQ_DEPTH
    typedef logic [IQ_PTR_W-1:0] iq_idx_t;

endpackage

`default_nettype wire

// File: issue_slot_if.sv
/*
 slot access between issue controller and an entry store
 two indexed writes, two indexed head reads
 payload type set per instance
 */

`default_nettype none

interface issue_slot_if
    import issue_pkg::*;
#(
    parameter type payload_t = logic
);

    // dispatch side, port 1 is the younger entry
    logic [1:0] wr_en;
    iq_idx_t    wr_idx [2];
    payload_t   wr_data [2];

    // issue side, head 0 is the oldest entry
    iq_idx_t    head_idx [2];
    payload_t   head_data [2];

    modport ctrl (
        output wr_en,
        output wr_idx,
        output wr_data,
        output head_idx,
        input  head_data
    );

    modport store (
        input  wr_en,
        input  wr_idx,
        input  wr_data,
        input  head_idx,
        output head_data
    );

endinterface

`default_nettype wire

// File: entry_store.sv
/*
 issue queue entry storage
 IQ_DEPTH payloads, two write ports, two head read ports
 */

`default_nettype none

module entry_store
    import core_cfg_pkg::*;
#(
    parameter type payload_t = logic
) (
    input  logic        clk,
    input  logic        rst_n,
    issue_slot_if.store slot
);

    // occupancy is tracked by the controller
    payload_t mem [IQ_DEPTH];

    logic [1:0] wr_ok;

    // block writes while the core is held in reset
    assign wr_ok = slot.wr_en & {2{rst_n}};

    always_ff @(posedge clk) begin
        for (int k = 0; k < 2; k++) begin
            if (wr_ok[k]) begin
                mem[slot.wr_idx[k]] <= slot.wr_data[k];
            end
        end
    end

    // head reads are combinational
    assign slot.head_data[0] = mem[slot.head_idx[0]];
    assign slot.head_data[1] = mem[slot.head_idx[1]];

endmodule

`default_nettype wire

// File: reg_file.sv
/*
 integer register file
 four combinational read ports, one write port
 same-cycle write forwarded to matching reads, x0 hardwired to zero
 */

`default_nettype none

module reg_file
    import core_cfg_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    // read ports, two per dispatch slot
    input  logic [REG_AW-1:0] raddr_i [4],
    output logic [XLEN-1:0]   rdata_o [4],

    // writeback
    input  logic              we_i,
    input  logic [REG_AW-1:0] waddr_i,
    input  logic [XLEN-1:0]   wdata_i
);

    logic [XLEN-1:0] regs [NUM_REGS];
    logic            wr_hit;

    // x0 never takes a write
    assign wr_hit = we_i && (waddr_i != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (wr_hit) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    always_comb begin
        for (int p = 0; p < 4; p++) begin
            if (raddr_i[p] == '0) begin
                rdata_o[p] = '0;
            end else if (wr_hit && (waddr_i == raddr_i[p])) begin
                // bypass the value landing at this edge
                rdata_o[p] = wdata_i;
            end else begin
                rdata_o[p] = regs[raddr_i[p]];
            end
        end
    end

endmodule

`default_nettype wire

// File: issue_ctrl.sv
/*
 issue queue controller
 busy bits, dispatch and issue pointers, dispatch acceptance
 dual-issue selection with the lane 1 RAW hazard rule
 */

`default_nettype none

module issue_ctrl
    import core_cfg_pkg::*;
    import issue_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    // dispatch
    input  logic              disp_valid_i,
    input  logic              disp_two_i,
    input  inst_pkt_t         disp_pkt_i [2],
    output logic              disp_ready_o,

    // register file reads, rs1/rs2 of slot 0 then slot 1
    output logic [REG_AW-1:0] rf_raddr_o [4],
    input  logic [XLEN-1:0]   rf_rdata_i [4],

    // entry stores
    issue_slot_if.ctrl        inst_slot,
    issue_slot_if.ctrl        opnd_slot,

    // issue lanes
    input  logic              iss_ready_i,
    output logic [1:0]        iss_valid_o,
    output inst_pkt_t         iss_pkt_o [2],
    output operands_t         iss_opnd_o [2]
);

    typedef logic [IQ_PTR_W:0] cnt_t;

    logic [IQ_DEPTH-1:0] busy;
    iq_idx_t             disp_ptr;
    iq_idx_t             iss_ptr;
    cnt_t                busy_cnt;
    logic                accept;
    logic [1:0]          disp_we;
    iq_idx_t             wr_idx [2];
    operands_t           disp_opnd [2];
    iq_idx_t             head_idx [2];
    inst_pkt_t           head_pkt [2];
    logic                lane1_raw;
    logic [1:0]          iss_fire;
    logic [1:0]          n_disp;
    logic [1:0]          n_iss;
    logic [IQ_DEPTH-1:0] set_mask;
    logic [IQ_DEPTH-1:0] clr_mask;

    // room for a full pair is required even for a single
    assign busy_cnt     = cnt_t'($countones(busy));
    assign disp_ready_o = (busy_cnt <= cnt_t'(IQ_DEPTH - 2));
    assign accept       = disp_valid_i && disp_ready_o;
    assign disp_we      = {accept && disp_two_i, accept};

    assign wr_idx[0] = disp_ptr;
    assign wr_idx[1] = disp_ptr + iq_idx_t'(1);

    // operand reads come straight from the incoming source fields
    assign rf_raddr_o[0] = disp_pkt_i[0].rs1;
    assign rf_raddr_o[1] = disp_pkt_i[0].rs2;
    assign rf_raddr_o[2] = disp_pkt_i[1].rs1;
    assign rf_raddr_o[3] = disp_pkt_i[1].rs2;

    assign disp_opnd[0] = '{op1: rf_rdata_i[0], op2: rf_rdata_i[1]};
    assign disp_opnd[1] = '{op1: rf_rdata_i[2], op2: rf_rdata_i[3]};

    assign inst_slot.wr_en      = disp_we;
    assign inst_slot.wr_idx[0]  = wr_idx[0];
    assign inst_slot.wr_idx[1]  = wr_idx[1];
    assign inst_slot.wr_data[0] = disp_pkt_i[0];
    assign inst_slot.wr_data[1] = disp_pkt_i[1];

    assign opnd_slot.wr_en      = disp_we;
    assign opnd_slot.wr_idx[0]  = wr_idx[0];
    assign opnd_slot.wr_idx[1]  = wr_idx[1];
    assign opnd_slot.wr_data[0] = disp_opnd[0];
    assign opnd_slot.wr_data[1] = disp_opnd[1];

    // the two oldest entries
    assign head_idx[0] = iss_ptr;
    assign head_idx[1] = iss_ptr + iq_idx_t'(1);

    assign inst_slot.head_idx[0] = head_idx[0];
    assign inst_slot.head_idx[1] = head_idx[1];
    assign opnd_slot.head_idx[0] = head_idx[0];
    assign opnd_slot.head_idx[1] = head_idx[1];

    assign head_pkt[0] = inst_slot.head_data[0];
    assign head_pkt[1] = inst_slot.head_data[1];

    // lane 1 reads what lane 0 writes, x0 excluded
    assign lane1_raw = head_pkt[0].we && (head_pkt[0].rd != '0) &&
                       ((head_pkt[1].rs1 == head_pkt[0].rd) ||
                        (head_pkt[1].rs2 == head_pkt[0].rd));

    assign iss_valid_o[0] = busy[head_idx[0]];
    assign iss_valid_o[1] = busy[head_idx[1]] && iss_valid_o[0] && !lane1_raw;

    assign iss_pkt_o[0]  = head_pkt[0];
    assign iss_pkt_o[1]  = head_pkt[1];
    assign iss_opnd_o[0] = opnd_slot.head_data[0];
    assign iss_opnd_o[1] = opnd_slot.head_data[1];

    assign iss_fire = iss_valid_o & {2{iss_ready_i}};
    assign n_disp   = {1'b0, disp_we[0]} + {1'b0, disp_we[1]};
    assign n_iss    = {1'b0, iss_fire[0]} + {1'b0, iss_fire[1]};

    always_comb begin
        set_mask = '0;
        clr_mask = '0;
        for (int k = 0; k < 2; k++) begin
            if (disp_we[k]) begin
                set_mask[wr_idx[k]] = 1'b1;
            end
            if (iss_fire[k]) begin
                clr_mask[head_idx[k]] = 1'b1;
            end
        end
    end

    // dispatched slots are always free, so set and clear never collide
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= '0;
            disp_ptr <= '0;
            iss_ptr  <= '0;
        end else begin
            busy     <= (busy & ~clr_mask) | set_mask;
            disp_ptr <= disp_ptr + iq_idx_t'(n_disp);
            iss_ptr  <= iss_ptr + iq_idx_t'(n_iss);
        end
    end

endmodule

`default_nettype wire

// File: issue_top.sv
/*
 dual-issue stage top level
 issue controller, instruction and operand stores, register file
 */

`default_nettype none

module issue_top
    import core_cfg_pkg::*;
    import issue_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic                 disp_valid_i,
    input  logic                 disp_two_i,
    input  logic [PC_W-1:0]      disp0_pc_i,
    input  logic [REG_AW-1:0]    disp0_rd_i,
    input  logic [REG_AW-1:0]    disp0_rs1_i,
    input  logic [REG_AW-1:0]    disp0_rs2_i,
    input  logic                 disp0_we_i,
    input  logic [XLEN-1:0]      disp0_imm_i,
    input  logic [DECINFO_W-1:0] disp0_info_i,
    input  logic [PC_W-1:0]      disp1_pc_i,
    input  logic [REG_AW-1:0]    disp1_rd_i,
    input  logic [REG_AW-1:0]    disp1_rs1_i,
    input  logic [REG_AW-1:0]    disp1_rs2_i,
    input  logic                 disp1_we_i,
    input  logic [XLEN-1:0]      disp1_imm_i,
    input  logic [DECINFO_W-1:0] disp1_info_i,
    output logic                 disp_ready_o,

    input  logic                 wb_we_i,
    input  logic [REG_AW-1:0]    wb_addr_i,
    input  logic [XLEN-1:0]      wb_data_i,

    input  logic                 iss_ready_i,
    output logic                 iss0_valid_o,
    output logic [PC_W-1:0]      iss0_pc_o,
    output logic [REG_AW-1:0]    iss0_rd_o,
    output logic                 iss0_we_o,
    output logic [XLEN-1:0]      iss0_imm_o,
    output logic [DECINFO_W-1:0] iss0_info_o,
    output logic [XLEN-1:0]      iss0_op1_o,
    output logic [XLEN-1:0]      iss0_op2_o,
    output logic                 iss1_valid_o,
    output logic [PC_W-1:0]      iss1_pc_o,
    output logic [REG_AW-1:0]    iss1_rd_o,
    output logic                 iss1_we_o,
    output logic [XLEN-1:0]      iss1_imm_o,
    output logic [DECINFO_W-1:0] iss1_info_o,
    output logic [XLEN-1:0]      iss1_op1_o,
    output logic [XLEN-1:0]      iss1_op2_o
);

    inst_pkt_t         disp_pkt [2];
    inst_pkt_t         iss_pkt [2];
    operands_t         iss_opnd [2];
    logic [1:0]        iss_valid;
    logic [REG_AW-1:0] rf_raddr [4];
    logic [XLEN-1:0]   rf_rdata [4];

    issue_slot_if #(.payload_t(inst_pkt_t)) inst_slot ();
    issue_slot_if #(.payload_t(operands_t)) opnd_slot ();

    assign disp_pkt[0] = '{pc: disp0_pc_i, rd: disp0_rd_i, rs1: disp0_rs1_i,
                           rs2: disp0_rs2_i, we: disp0_we_i, imm: disp0_imm_i,
                           info: disp0_info_i};
    assign disp_pkt[1] = '{pc: disp1_pc_i, rd: disp1_rd_i, rs1: disp1_rs1_i,
                           rs2: disp1_rs2_i, we: disp1_we_i, imm: disp1_imm_i,
                           info: disp1_info_i};

    issue_ctrl i_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .disp_valid_i (disp_valid_i),
        .disp_two_i   (disp_two_i),
        .disp_pkt_i   (disp_pkt),
        .disp_ready_o (disp_ready_o),
        .rf_raddr_o   (rf_raddr),
        .rf_rdata_i   (rf_rdata),
        .inst_slot    (inst_slot.ctrl),
        .opnd_slot    (opnd_slot.ctrl),
        .iss_ready_i  (iss_ready_i),
        .iss_valid_o  (iss_valid),
        .iss_pkt_o    (iss_pkt),
        .iss_opnd_o   (iss_opnd)
    );

    entry_store #(.payload_t(inst_pkt_t)) i_inst_store (
        .clk   (clk),
        .rst_n (rst_n),
        .slot  (inst_slot.store)
    );

    entry_store #(.payload_t(operands_t)) i_opnd_store (
        .clk   (clk),
        .rst_n (rst_n),
        .slot  (opnd_slot.store)
    );

    reg_file i_rf (
        .clk     (clk),
        .rst_n   (rst_n),
        .raddr_i (rf_raddr),
        .rdata_o (rf_rdata),
        .we_i    (wb_we_i),
        .waddr_i (wb_addr_i),
        .wdata_i (wb_data_i)
    );

    // lane 0
    assign iss0_valid_o = iss_valid[0];
    assign iss0_pc_o    = iss_pkt[0].pc;
    assign iss0_rd_o    = iss_pkt[0].rd;
    assign iss0_we_o    = iss_pkt[0].we;
    assign iss0_imm_o   = iss_pkt[0].imm;
    assign iss0_info_o  = iss_pkt[0].info;
    assign iss0_op1_o   = iss_opnd[0].op1;
    assign iss0_op2_o   = iss_opnd[0].op2;

    // lane 1
    assign iss1_valid_o = iss_valid[1];
    assign iss1_pc_o    = iss_pkt[1].pc;
    assign iss1_rd_o    = iss_pkt[1].rd;
    assign iss1_we_o    = iss_pkt[1].we;
    assign iss1_imm_o   = iss_pkt[1].imm;
    assign iss1_info_o  = iss_pkt[1].info;
    assign iss1_op1_o   = iss_opnd[1].op1;
    assign iss1_op2_o   = iss_opnd[1].op2;

endmodule

`default_nettype wire

// File: tb_issue_chk.sv
/*
 concurrent checks on the issue controller
 lane order, dispatch room and offer stability under back-pressure
 */

`default_nettype none

module tb_issue_chk
    import core_cfg_pkg::*;
    import issue_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic [IQ_DEPTH-1:0] busy_i,
    input  iq_idx_t             disp_ptr_i,
    input  iq_idx_t             iss_ptr_i,
    input  logic                disp_ready_i,
    input  logic [1:0]          iss_valid_i,
    input  logic                iss_ready_i,
    input  inst_pkt_t           pkt0_i,
    input  inst_pkt_t           pkt1_i,
    input  operands_t           opnd0_i,
    input  operands_t           opnd1_i
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [IQ_PTR_W:0] occ;
    iq_idx_t           ptr_dist;

    // occupancy from the pointer distance, equal pointers mean empty or full
    assign ptr_dist = disp_ptr_i - iss_ptr_i;
    assign occ      = (ptr_dist != '0) ? {1'b0, ptr_dist} :
                      (busy_i[iss_ptr_i] ? (IQ_PTR_W+1)'(IQ_DEPTH) : '0);

    // lane 1 never runs ahead of lane 0 and needs two queued entries
    a_lane_order: assert property (@(posedge clk) disable iff (!rst_n)
        iss_valid_i[1] |-> (iss_valid_i[0] && occ >= 2))
        else $error("lane 1 valid while lane 0 is idle");

    a_disp_room: assert property (@(posedge clk) disable iff (!rst_n)
        (occ > IQ_DEPTH - 2) |-> !disp_ready_i)
        else $error("dispatch ready with fewer than two free entries");

    // a stalled offer holds its payload
    a_hold_lane0: assert property (@(posedge clk) disable iff (!rst_n)
        (iss_valid_i[0] && !iss_ready_i) |=>
        (iss_valid_i[0] && $stable(pkt0_i) && $stable(opnd0_i)))
        else $error("lane 0 offer changed under back-pressure");

    a_hold_lane1: assert property (@(posedge clk) disable iff (!rst_n)
        (iss_valid_i[1] && !iss_ready_i) |=>
        (iss_valid_i[1] && $stable(pkt1_i) && $stable(opnd1_i)))
        else $error("lane 1 offer changed under back-pressure");

endmodule

`default_nettype wire

// File: tb_issue.sv
/*
 testbench for the dual-issue stage
 queue and register file models, compare tasks, directed tests, watchdog
 */

`default_nettype none

module tb_issue
    import core_cfg_pkg::*;
    import issue_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 4;
    localparam int WAIT_LIMIT = 64;
    // cycle budget of each test
    localparam int RESET_CYC   = 10;
    localparam int ORDER_CYC   = 150;
    localparam int OPND_CYC    = 150;
    localparam int HAZARD_CYC  = 100;
    localparam int BP_CYC      = 100;
    localparam int WATCHDOG_NS = 2 * CLK_PERIOD *
                                 (RESET_CYC + ORDER_CYC + OPND_CYC + HAZARD_CYC + BP_CYC);

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 disp_valid;
    logic                 disp_two;
    inst_pkt_t            pkt0;
    inst_pkt_t            pkt1;
    logic                 wb_we;
    logic [REG_AW-1:0]    wb_addr;
    logic [XLEN-1:0]      wb_data;
    logic                 iss_ready;
    logic                 disp_ready;
    logic                 iss0_valid, iss1_valid;
    logic [PC_W-1:0]      iss0_pc, iss1_pc;
    logic [REG_AW-1:0]    iss0_rd, iss1_rd;
    logic                 iss0_we, iss1_we;
    logic [XLEN-1:0]      iss0_imm, iss1_imm;
    logic [DECINFO_W-1:0] iss0_info, iss1_info;
    logic [XLEN-1:0]      iss0_op1, iss0_op2, iss1_op1, iss1_op2;
    inst_pkt_t            got_pkt0, got_pkt1;
    operands_t            got_opnd0, got_opnd1;

    // reference models
    inst_pkt_t            exp_pkt_q [$];
    operands_t            exp_opnd_q [$];
    logic [XLEN-1:0]      rf_model [NUM_REGS] = '{default: '0};
    logic                 lane1_exp;

    integer               seed = 28665;
    logic [PC_W-1:0]      next_pc = 32'h0000_1000;
    int                   n_tests = 0;
    int                   n_checks = 0;
    int                   n_errors = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    issue_top i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .disp_valid_i (disp_valid),
        .disp_two_i   (disp_two),
        .disp0_pc_i   (pkt0.pc),
        .disp0_rd_i   (pkt0.rd),
        .disp0_rs1_i  (pkt0.rs1),
        .disp0_rs2_i  (pkt0.rs2),
        .disp0_we_i   (pkt0.we),
        .disp0_imm_i  (pkt0.imm),
        .disp0_info_i (pkt0.info),
        .disp1_pc_i   (pkt1.pc),
        .disp1_rd_i   (pkt1.rd),
        .disp1_rs1_i  (pkt1.rs1),
        .disp1_rs2_i  (pkt1.rs2),
        .disp1_we_i   (pkt1.we),
        .disp1_imm_i  (pkt1.imm),
        .disp1_info_i (pkt1.info),
        .disp_ready_o (disp_ready),
        .wb_we_i      (wb_we),
        .wb_addr_i    (wb_addr),
        .wb_data_i    (wb_data),
        .iss_ready_i  (iss_ready),
        .iss0_valid_o (iss0_valid),
        .iss0_pc_o    (iss0_pc),
        .iss0_rd_o    (iss0_rd),
        .iss0_we_o    (iss0_we),
        .iss0_imm_o   (iss0_imm),
        .iss0_info_o  (iss0_info),
        .iss0_op1_o   (iss0_op1),
        .iss0_op2_o   (iss0_op2),
        .iss1_valid_o (iss1_valid),
        .iss1_pc_o    (iss1_pc),
        .iss1_rd_o    (iss1_rd),
        .iss1_we_o    (iss1_we),
        .iss1_imm_o   (iss1_imm),
        .iss1_info_o  (iss1_info),
        .iss1_op1_o   (iss1_op1),
        .iss1_op2_o   (iss1_op2)
    );

    bind issue_ctrl tb_issue_chk i_chk (
        .clk          (clk),
        .rst_n        (rst_n),
        .busy_i       (busy),
        .disp_ptr_i   (disp_ptr),
        .iss_ptr_i    (iss_ptr),
        .disp_ready_i (disp_ready_o),
        .iss_valid_i  (iss_valid_o),
        .iss_ready_i  (iss_ready_i),
        .pkt0_i       (iss_pkt_o[0]),
        .pkt1_i       (iss_pkt_o[1]),
        .opnd0_i      (iss_opnd_o[0]),
        .opnd1_i      (iss_opnd_o[1])
    );

    // source fields do not leave the top level
    assign got_pkt0 = '{pc: iss0_pc, rd: iss0_rd, rs1: '0, rs2: '0, we: iss0_we,
                        imm: iss0_imm, info: iss0_info};
    assign got_pkt1 = '{pc: iss1_pc, rd: iss1_rd, rs1: '0, rs2: '0, we: iss1_we,
                        imm: iss1_imm, info: iss1_info};
    assign got_opnd0 = '{op1: iss0_op1, op2: iss0_op2};
    assign got_opnd1 = '{op1: iss1_op1, op2: iss1_op2};

    task automatic check_pkt(string lane, inst_pkt_t got, inst_pkt_t exp);
        n_checks++;
        if (got.pc !== exp.pc || got.rd !== exp.rd || got.we !== exp.we ||
            got.imm !== exp.imm || got.info !== exp.info) begin
            n_errors++;
            $display("error at %0t ns: %s packet pc %h rd %0d imm %h, expected pc %h rd %0d imm %h",
                     $time, lane, got.pc, got.rd, got.imm, exp.pc, exp.rd, exp.imm);
        end
    endtask

    task automatic check_opnd(string lane, operands_t got, operands_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error at %0t ns: %s operands %h %h, expected %h %h",
                     $time, lane, got.op1, got.op2, exp.op1, exp.op2);
        end
    endtask

    task automatic check_flag(string what, logic got, logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // younger reads a register that the older one writes
    function automatic logic reads_dest(inst_pkt_t older, inst_pkt_t younger);
        return older.we && (older.rd != '0) &&
               ((younger.rs1 == older.rd) || (younger.rs2 == older.rd));
    endfunction

    function automatic void push_entry(inst_pkt_t p);
        operands_t o;
        o.op1 = rf_model[p.rs1];
        o.op2 = rf_model[p.rs2];
        exp_pkt_q.push_back(p);
        exp_opnd_q.push_back(o);
    endfunction

    function automatic inst_pkt_t rand_pkt();
        inst_pkt_t p;
        p.pc    = next_pc;
        p.rd    = REG_AW'($random(seed));
        p.rs1   = REG_AW'($random(seed));
        p.rs2   = REG_AW'($random(seed));
        p.we    = 1'($random(seed));
        p.imm   = XLEN'($random(seed));
        p.info  = DECINFO_W'($random(seed));
        next_pc = next_pc + 32'd4;
        return p;
    endfunction

    // model step per edge, issue first, then writeback, then dispatch
    always @(posedge clk) begin
        if (rst_n) begin
            check_flag("disp_ready", disp_ready, exp_pkt_q.size() <= IQ_DEPTH - 2);
            check_flag("lane 0 valid", iss0_valid, exp_pkt_q.size() > 0);
            lane1_exp = (exp_pkt_q.size() > 1) && !reads_dest(exp_pkt_q[0], exp_pkt_q[1]);
            check_flag("lane 1 valid", iss1_valid, lane1_exp);
            if (iss_ready && iss0_valid && exp_pkt_q.size() > 0) begin
                check_pkt("lane 0", got_pkt0, exp_pkt_q.pop_front());
                check_opnd("lane 0", got_opnd0, exp_opnd_q.pop_front());
                if (iss1_valid && exp_pkt_q.size() > 0) begin
                    check_pkt("lane 1", got_pkt1, exp_pkt_q.pop_front());
                    check_opnd("lane 1", got_opnd1, exp_opnd_q.pop_front());
                end
            end
            if (wb_we && wb_addr != '0) begin
                rf_model[wb_addr] = wb_data;
            end
            if (disp_valid && disp_ready) begin
                push_entry(pkt0);
                if (disp_two) begin
                    push_entry(pkt1);
                end
            end
        end
    end

    task automatic dispatch(inst_pkt_t a, inst_pkt_t b, logic two, logic wr,
                            logic [REG_AW-1:0] addr, logic [XLEN-1:0] data);
        int waited;
        waited = 0;
        @(negedge clk);
        pkt0       = a;
        pkt1       = b;
        disp_two   = two;
        disp_valid = 1'b1;
        wb_we      = wr;
        wb_addr    = addr;
        wb_data    = data;
        while (!disp_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!disp_ready) begin
            n_errors++;
            $display("dispatch was never accepted at %0t ns", $time);
        end
        @(negedge clk);
        disp_valid = 1'b0;
        wb_we      = 1'b0;
    endtask

    task automatic writeback(logic [REG_AW-1:0] addr, logic [XLEN-1:0] data);
        @(negedge clk);
        wb_we   = 1'b1;
        wb_addr = addr;
        wb_data = data;
        @(negedge clk);
        wb_we   = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_pkt_q.size() != 0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_pkt_q.size() != 0) begin
            n_errors++;
            $display("queue did not drain, %0d entries still expected", exp_pkt_q.size());
        end
        check_flag("lane 0 valid after drain", iss0_valid, 1'b0);
    endtask

    task automatic test_done(string name, int err0);
        n_tests++;
        $display("test %s: %0d errors", name, n_errors - err0);
    endtask

    task automatic test_reset();
        int err0;
        err0 = n_errors;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_flag("disp_ready after reset", disp_ready, 1'b1);
        check_flag("lane 0 valid after reset", iss0_valid, 1'b0);
        check_flag("lane 1 valid after reset", iss1_valid, 1'b0);
        test_done("reset", err0);
    endtask

    task automatic test_order();
        int   err0;
        logic two;
        err0 = n_errors;
        iss_ready = 1'b1;
        for (int i = 0; i < 16; i++) begin
            two = 1'($random(seed));
            dispatch(rand_pkt(), rand_pkt(), two, 1'b0, '0, '0);
        end
        wait_drain();
        test_done("order and payload", err0);
    endtask

    task automatic test_operands();
        int        err0;
        inst_pkt_t a;
        inst_pkt_t b;
        err0 = n_errors;
        iss_ready = 1'b1;
        // x0 is written too and must stay zero
        for (int r = 0; r < 8; r++) begin
            writeback(REG_AW'(r), XLEN'($random(seed)));
        end
        a = rand_pkt();
        b = rand_pkt();
        a.rs1 = 5'd0;
        a.rs2 = 5'd3;
        b.rs1 = 5'd7;
        b.rs2 = 5'd1;
        dispatch(a, b, 1'b1, 1'b0, '0, '0);
        a = rand_pkt();
        a.rs1 = 5'd4;
        a.rs2 = 5'd2;
        dispatch(a, rand_pkt(), 1'b1, 1'b1, 5'd4, XLEN'($random(seed)));
        for (int i = 0; i < 10; i++) begin
            dispatch(rand_pkt(), rand_pkt(), 1'b1, 1'b1, REG_AW'($random(seed)),
                     XLEN'($random(seed)));
        end
        wait_drain();
        test_done("operands", err0);
    endtask

    task automatic pair_offer(inst_pkt_t a, inst_pkt_t b, logic together);
        int waited;
        waited = 0;
        dispatch(a, b, 1'b1, 1'b0, '0, '0);
        while (!iss0_valid && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        check_flag("lane 1 on first offer", iss1_valid, together);
        wait_drain();
    endtask

    task automatic test_hazard();
        int        err0;
        inst_pkt_t a;
        inst_pkt_t b;
        err0 = n_errors;
        iss_ready = 1'b1;
        a = rand_pkt();
        b = rand_pkt();
        a.we  = 1'b1;
        a.rd  = 5'd5;
        b.rs1 = 5'd5;
        pair_offer(a, b, 1'b0);
        b.rs1 = 5'd12;
        b.rs2 = 5'd5;
        pair_offer(a, b, 1'b0);
        // x0 destination carries no dependence
        a.rd  = 5'd0;
        b.rs1 = 5'd0;
        b.rs2 = 5'd0;
        pair_offer(a, b, 1'b1);
        a.we  = 1'b0;
        a.rd  = 5'd6;
        b.rs1 = 5'd6;
        b.rs2 = 5'd6;
        pair_offer(a, b, 1'b1);
        test_done("hazard", err0);
    endtask

    task automatic test_backpressure();
        int err0;
        int fills;
        err0  = n_errors;
        fills = 0;
        @(negedge clk);
        iss_ready = 1'b0;
        dispatch(rand_pkt(), rand_pkt(), 1'b0, 1'b0, '0, '0);
        while (disp_ready && fills < IQ_DEPTH) begin
            dispatch(rand_pkt(), rand_pkt(), 1'b1, 1'b0, '0, '0);
            fills++;
        end
        check_flag("at most two entries free", exp_pkt_q.size() >= IQ_DEPTH - 2, 1'b1);
        check_flag("disp_ready when full", disp_ready, 1'b0);
        repeat (4) @(negedge clk);
        iss_ready = 1'b1;
        wait_drain();
        test_done("back-pressure", err0);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests completed");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        rst_n      = 1'b0;
        disp_valid = 1'b0;
        disp_two   = 1'b0;
        pkt0       = '0;
        pkt1       = '0;
        wb_we      = 1'b0;
        wb_addr    = '0;
        wb_data    = '0;
        iss_ready  = 1'b0;
        test_reset();
        test_order();
        test_operands();
        test_hazard();
        test_backpressure();
        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
core_cfg_pkg.sv
issue_pkg.sv
issue_slot_if.sv
entry_store.sv
reg_file.sv
issue_ctrl.sv
issue_top.sv
tb_issue_chk.sv
tb_issue.sv

// File: run.sh
#!/bin/sh
# build and run the issue stage testbench with Verilator

verilator --binary --timing --assert --top-module tb_issue -f list.f -o tb_issue_sim \
    > build.log 2>&1 \
    && ./obj_dir/tb_issue_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q "Finished with errors" sim.log && exit 1 || exit 0
